//--- Bender.yml
package:
  name: archie_mem

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/archie_mem_pkg.sv
      - rtl/mem_bus_if.sv
      - rtl/rom_loader.sv
      - rtl/mem_arbiter.sv
      - rtl/word_ram.sv
      - rtl/archie_mem_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/archie_mem_tb.sv

//--- archie_mem.f
+incdir+rtl
rtl/archie_mem_pkg.sv
rtl/mem_bus_if.sv
rtl/rom_loader.sv
rtl/mem_arbiter.sv
rtl/word_ram.sv
rtl/archie_mem_top.sv
verif/tb_clock_gen.sv
verif/archie_mem_tb.sv

//--- rtl/archie_mem_pkg.sv
`include "archie_mem_settings.svh"

package archie_mem_pkg;

	// one word on the shared bus
	typedef logic [`ARCHIE_DATA_W-1:0] word_t;

	// byte enables, bit n covers byte lane n
	typedef logic [`ARCHIE_SEL_W-1:0] sel_t;

	// word address, bits 23..2 of either master's address
	typedef logic [`ARCHIE_DL_ADDR_W-3:0] word_addr_t;

	// image index from the download channel
	typedef logic [7:0] dl_index_t;

endpackage

//--- rtl/archie_mem_settings.svh
`ifndef ARCHIE_MEM_SETTINGS_SVH
`define ARCHIE_MEM_SETTINGS_SVH

// shared bus word and byte lanes
`define ARCHIE_DATA_W 32
`define ARCHIE_SEL_W 4

// loader sends byte addresses, core sends word addresses (bits 26..2)
`define ARCHIE_DL_ADDR_W 24
`define ARCHIE_CORE_ADDR_W 25

// words decoded by the stand-in RAM, 1024 deep
`define ARCHIE_RAM_AW 10

// image indexes that take the memory away from the core
`define ARCHIE_IDX_ROM 1
`define ARCHIE_IDX_IMG 2

`endif

//--- rtl/archie_mem_top.sv
`timescale 1ns/1ps
`include "archie_mem_settings.svh"

module archie_mem_top
	import archie_mem_pkg::*;
(
	input  logic                           clk_sys,
	input  logic                           arst_n_i,
	input  logic                           dl_active_i,
	input  dl_index_t                      dl_index_i,
	input  logic                           dl_we_i,
	input  logic [`ARCHIE_DL_ADDR_W-1:0]   dl_addr_i,
	input  sel_t                           dl_sel_i,
	input  word_t                          dl_data_i,
	output logic                           dl_busy_o,
	input  logic                           reset_btn_i,
	input  logic                           core_cyc_i,
	input  logic                           core_stb_i,
	input  logic                           core_we_i,
	input  sel_t                           core_sel_i,
	input  logic [`ARCHIE_CORE_ADDR_W-1:0] core_addr_i,
	input  word_t                          core_data_i,
	output word_t                          core_data_o,
	output logic                           core_ack_o,
	output logic                           rom_ready_o,
	output logic                           sys_reset_o
);

	logic loader_owns;

	mem_bus_if ldr_bus ();
	mem_bus_if core_bus ();
	mem_bus_if ram_bus ();

	// core address is already word based, keep bits 23..2
	assign core_bus.cyc   = core_cyc_i;
	assign core_bus.stb   = core_stb_i;
	assign core_bus.we    = core_we_i;
	assign core_bus.sel   = core_sel_i;
	assign core_bus.adr   = core_addr_i[$bits(word_addr_t)-1:0];
	assign core_bus.dat_w = core_data_i;
	assign core_data_o    = core_bus.dat_r;
	assign core_ack_o     = core_bus.ack;

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_we_i       (dl_we_i),
		.dl_addr_i     (dl_addr_i),
		.dl_sel_i      (dl_sel_i),
		.dl_data_i     (dl_data_i),
		.reset_btn_i   (reset_btn_i),
		.bus           (ldr_bus.master),
		.loader_owns_o (loader_owns),
		.dl_busy_o     (dl_busy_o),
		.rom_ready_o   (rom_ready_o),
		.sys_reset_o   (sys_reset_o)
	);

	mem_arbiter u_mem_arbiter (
		.loader_owns_i (loader_owns),
		.ldr           (ldr_bus.slave),
		.core          (core_bus.slave),
		.ram           (ram_bus.master)
	);

	word_ram u_word_ram (
		.clk_sys  (clk_sys),
		.arst_n_i (arst_n_i),
		.bus      (ram_bus.slave)
	);

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import archie_mem_pkg::*;
(
	input  logic      loader_owns_i,
	mem_bus_if.slave  ldr,
	mem_bus_if.slave  core,
	mem_bus_if.master ram
);

	// loader wins the request side for the whole download
	assign ram.cyc   = loader_owns_i ? ldr.cyc   : core.cyc;
	assign ram.stb   = loader_owns_i ? ldr.stb   : core.stb;
	assign ram.we    = loader_owns_i ? ldr.we    : core.we;
	assign ram.sel   = loader_owns_i ? ldr.sel   : core.sel;
	assign ram.adr   = loader_owns_i ? ldr.adr   : core.adr;
	assign ram.dat_w = loader_owns_i ? ldr.dat_w : core.dat_w;

	// read data goes to both masters
	assign ldr.dat_r  = ram.dat_r;
	assign core.dat_r = ram.dat_r;

	// core just stalls during a download
	assign ldr.ack  = loader_owns_i && ram.ack;
	assign core.ack = !loader_owns_i && ram.ack;

	// ownership must not move while the RAM serves a request
	a_ldr_ack_held: assert property (
		@(negedge ram.ack)
		loader_owns_i |-> ldr.cyc && ldr.stb
	);

	a_core_ack_held: assert property (
		@(negedge ram.ack)
		!loader_owns_i |-> core.cyc && core.stb
	);

endmodule

//--- rtl/mem_bus_if.sv
`timescale 1ns/1ps

// one Wishbone-style master port onto the shared memory
interface mem_bus_if
	import archie_mem_pkg::*;
();

	logic       cyc;
	logic       stb;
	logic       we;
	sel_t       sel;
	word_addr_t adr;
	word_t      dat_w;
	word_t      dat_r;
	logic       ack;

	// master holds the request until it sees ack
	modport master (
		output cyc, stb, we, sel, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, sel, adr, dat_w,
		output dat_r, ack
	);

endinterface

//--- rtl/rom_loader.sv
`timescale 1ns/1ps
`include "archie_mem_settings.svh"

module rom_loader
	import archie_mem_pkg::*;
(
	input  logic                         clk_sys,
	input  logic                         arst_n_i,
	input  logic                         dl_active_i,
	input  dl_index_t                    dl_index_i,
	input  logic                         dl_we_i,
	input  logic [`ARCHIE_DL_ADDR_W-1:0] dl_addr_i,
	input  sel_t                         dl_sel_i,
	input  word_t                        dl_data_i,
	input  logic                         reset_btn_i,
	mem_bus_if.master                    bus,
	output logic                         loader_owns_o,
	output logic                         dl_busy_o,
	output logic                         rom_ready_o,
	output logic                         sys_reset_o
);

	logic       owns;
	logic       owns_q;
	logic       accept;
	logic       stb_q;
	logic       rom_ready_q;
	word_addr_t adr_q;
	sel_t       sel_q;
	word_t      dat_q;

	// only ROM and disk images go to shared memory
	assign owns = dl_active_i &&
		(dl_index_i == dl_index_t'(`ARCHIE_IDX_ROM) ||
		 dl_index_i == dl_index_t'(`ARCHIE_IDX_IMG));

	// pulses for other indexes are dropped here
	assign accept = dl_we_i && owns;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			owns_q      <= 1'b0;
			stb_q       <= 1'b0;
			rom_ready_q <= 1'b0;
		end else begin
			owns_q <= owns;
			// end of a ROM download releases the system
			if (owns_q && !owns)
				rom_ready_q <= 1'b1;
			if (accept)
				stb_q <= 1'b1;
			else if (bus.ack)
				stb_q <= 1'b0;
		end
	end

	// request payload, held while the strobe waits
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			adr_q <= dl_addr_i[`ARCHIE_DL_ADDR_W-1:2];
			sel_q <= dl_sel_i;
			dat_q <= dl_data_i;
		end
	end

	assign bus.cyc   = stb_q;
	assign bus.stb   = stb_q;
	assign bus.we    = 1'b1;
	assign bus.sel   = sel_q;
	assign bus.adr   = adr_q;
	assign bus.dat_w = dat_q;

	assign loader_owns_o = owns;
	assign dl_busy_o     = stb_q;
	assign rom_ready_o   = rom_ready_q;
	assign sys_reset_o   = !rom_ready_q || reset_btn_i;

	// the download side must wait for the previous word to be written
	a_no_overrun: assert property (
		@(posedge clk_sys) disable iff (!arst_n_i)
		dl_we_i |-> !stb_q
	);

endmodule

//--- rtl/word_ram.sv
`timescale 1ns/1ps
`include "archie_mem_settings.svh"

module word_ram
	import archie_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n_i,
	mem_bus_if.slave bus
);

	localparam int unsigned DEPTH  = 2 ** `ARCHIE_RAM_AW;
	localparam int unsigned BYTE_W = `ARCHIE_DATA_W / `ARCHIE_SEL_W;

	word_t                     mem [DEPTH];
	word_t                     rdata_q;
	logic                      ack_q;
	logic                      req;
	logic [`ARCHIE_RAM_AW-1:0] waddr;

	// upper address bits alias onto the same words
	assign waddr = bus.adr[`ARCHIE_RAM_AW-1:0];

	// ack low keeps a held strobe from being served twice
	assign req = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clk_sys) begin
		if (req) begin
			if (bus.we) begin
				for (int b = 0; b < `ARCHIE_SEL_W; b++) begin
					if (bus.sel[b])
						mem[waddr][b*BYTE_W +: BYTE_W] <= bus.dat_w[b*BYTE_W +: BYTE_W];
				end
			end else begin
				rdata_q <= mem[waddr];
			end
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;

	a_ack_after_req: assert property (
		@(posedge clk_sys) disable iff (!arst_n_i)
		bus.ack |-> $past(bus.cyc && bus.stb && !bus.ack)
	);

endmodule

//--- verif/archie_mem_tb.sv
`timescale 1ns/1ps
`include "archie_mem_settings.svh"

module archie_mem_tb
	import archie_mem_pkg::*;
();

	localparam int unsigned DEPTH   = 2 ** `ARCHIE_RAM_AW;
	localparam int unsigned TIMEOUT = 50;
	localparam int unsigned N_LOAD  = 64;

	typedef logic [`ARCHIE_RAM_AW-1:0] ram_idx_t;

	logic                           clk_sys;
	logic                           arst_n;
	logic                           dl_active;
	dl_index_t                      dl_index;
	logic                           dl_we;
	logic [`ARCHIE_DL_ADDR_W-1:0]   dl_addr;
	sel_t                           dl_sel;
	word_t                          dl_data;
	logic                           dl_busy;
	logic                           reset_btn;
	logic                           core_cyc;
	logic                           core_stb;
	logic                           core_we;
	sel_t                           core_sel;
	logic [`ARCHIE_CORE_ADDR_W-1:0] core_addr;
	word_t                          core_wdata;
	word_t                          core_rdata;
	logic                           core_ack;
	logic                           rom_ready;
	logic                           sys_reset;

	// expected memory contents, X where no byte was ever written
	word_t       model [DEPTH];
	ram_idx_t    loaded [$];
	logic [31:0] rng_state = 32'd6;

	tb_clock_gen u_tb_clock_gen (
		.clk_sys  (clk_sys),
		.arst_n_o (arst_n)
	);

	archie_mem_top u_archie_mem_top (
		.clk_sys     (clk_sys),
		.arst_n_i    (arst_n),
		.dl_active_i (dl_active),
		.dl_index_i  (dl_index),
		.dl_we_i     (dl_we),
		.dl_addr_i   (dl_addr),
		.dl_sel_i    (dl_sel),
		.dl_data_i   (dl_data),
		.dl_busy_o   (dl_busy),
		.reset_btn_i (reset_btn),
		.core_cyc_i  (core_cyc),
		.core_stb_i  (core_stb),
		.core_we_i   (core_we),
		.core_sel_i  (core_sel),
		.core_addr_i (core_addr),
		.core_data_i (core_wdata),
		.core_data_o (core_rdata),
		.core_ack_o  (core_ack),
		.rom_ready_o (rom_ready),
		.sys_reset_o (sys_reset)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic ram_idx_t pick_loaded();
		logic [31:0] r;
		r = next_rand();
		return loaded[r % loaded.size()];
	endfunction

	// only the selected byte lanes take the new data
	function automatic word_t merge_bytes(input word_t old, input word_t data, input sel_t sel);
		word_t res;
		res = old;
		for (int b = 0; b < `ARCHIE_SEL_W; b++) begin
			if (sel[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_latency(input string name, input int unsigned got, input int unsigned exp);
		if (got != exp)
			stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// one write pulse from the download side, taken says whether memory claims it
	task automatic loader_write(input ram_idx_t idx, input sel_t sel, input word_t data,
			input logic taken);
		logic [`ARCHIE_DL_ADDR_W-1:0] byte_addr;
		int unsigned                  waited;
		byte_addr = '0;
		byte_addr[`ARCHIE_RAM_AW+1:0] = {idx, 2'b00};
		@(posedge clk_sys);
		dl_we   <= 1'b1;
		dl_addr <= byte_addr;
		dl_sel  <= sel;
		dl_data <= data;
		@(posedge clk_sys);
		dl_we <= 1'b0;
		@(negedge clk_sys);
		check_flag("dl_busy_o", dl_busy, taken);
		waited = 0;
		while (dl_busy) begin
			// core is stalled for the whole download
			check_flag("core_ack_o", core_ack, 1'b0);
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("timeout waiting for dl_busy_o to fall");
			@(negedge clk_sys);
		end
		if (taken)
			model[idx] = merge_bytes(model[idx], data, sel);
	endtask

	task automatic core_start(input logic we, input ram_idx_t idx, input sel_t sel,
			input word_t data);
		logic [`ARCHIE_CORE_ADDR_W-1:0] word_addr;
		word_addr = '0;
		word_addr[`ARCHIE_RAM_AW-1:0] = idx;
		@(posedge clk_sys);
		core_cyc   <= 1'b1;
		core_stb   <= 1'b1;
		core_we    <= we;
		core_sel   <= sel;
		core_addr  <= word_addr;
		core_wdata <= data;
	endtask

	// wait for ack, then drop the strobe on the ack edge
	task automatic core_finish(input logic timed, output word_t rdata);
		int unsigned waited;
		ram_idx_t    idx;
		waited = 0;
		@(negedge clk_sys);
		while (!core_ack) begin
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("timeout waiting for core_ack_o");
			@(negedge clk_sys);
		end
		if (timed)
			check_latency("core_ack_o latency", waited, 1);
		rdata = core_rdata;
		idx = core_addr[`ARCHIE_RAM_AW-1:0];
		if (core_we)
			model[idx] = merge_bytes(model[idx], core_wdata, core_sel);
		@(posedge clk_sys);
		core_cyc <= 1'b0;
		core_stb <= 1'b0;
		core_we  <= 1'b0;
	endtask

	task automatic core_read_check(input ram_idx_t idx);
		word_t rd;
		core_start(1'b0, idx, '0, '0);
		core_finish(1'b1, rd);
		check_word("core_data_o", rd, model[idx]);
	endtask

	task automatic core_write(input ram_idx_t idx, input sel_t sel, input word_t data);
		word_t rd;
		core_start(1'b1, idx, sel, data);
		core_finish(1'b1, rd);
	endtask

	initial begin
		logic [31:0] r;
		ram_idx_t    idx;
		ram_idx_t    ignored [$];
		word_t       rd;
		int unsigned waited;
		dl_active  <= 1'b0;
		dl_index   <= '0;
		dl_we      <= 1'b0;
		dl_addr    <= '0;
		dl_sel     <= '0;
		dl_data    <= '0;
		reset_btn  <= 1'b0;
		core_cyc   <= 1'b0;
		core_stb   <= 1'b0;
		core_we    <= 1'b0;
		core_sel   <= '0;
		core_addr  <= '0;
		core_wdata <= '0;

		@(negedge clk_sys);
		check_flag("rom_ready_o", rom_ready, 1'b0);
		check_flag("sys_reset_o", sys_reset, 1'b1);
		check_flag("core_ack_o", core_ack, 1'b0);
		check_flag("dl_busy_o", dl_busy, 1'b0);
		waited = 0;
		while (!arst_n) begin
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("timeout waiting for reset release");
			@(negedge clk_sys);
		end
		check_flag("rom_ready_o", rom_ready, 1'b0);
		check_flag("sys_reset_o", sys_reset, 1'b1);
		check_flag("core_ack_o", core_ack, 1'b0);
		check_flag("dl_busy_o", dl_busy, 1'b0);

		// ROM download, index 1
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= dl_index_t'(`ARCHIE_IDX_ROM);
		for (int i = 0; i < N_LOAD; i++) begin
			r = next_rand();
			idx = r[`ARCHIE_RAM_AW-1:0];
			loaded.push_back(idx);
			r = next_rand();
			loader_write(idx, r[3:0], next_rand(), 1'b1);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		@(negedge clk_sys);
		check_flag("rom_ready_o", rom_ready, 1'b0);
		@(negedge clk_sys);
		check_flag("rom_ready_o", rom_ready, 1'b1);
		check_flag("sys_reset_o", sys_reset, 1'b0);

		for (int i = 0; i < 32; i++)
			core_read_check(pick_loaded());

		// mixed core traffic
		for (int i = 0; i < 48; i++) begin
			r = next_rand();
			idx = pick_loaded();
			if (r[0])
				core_write(idx, r[7:4], next_rand());
			else
				core_read_check(idx);
		end

		// core write held off by a disk image download
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= dl_index_t'(`ARCHIE_IDX_IMG);
		r = next_rand();
		core_start(1'b1, pick_loaded(), r[3:0], next_rand());
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			idx = r[`ARCHIE_RAM_AW-1:0];
			loaded.push_back(idx);
			loader_write(idx, 4'hf, next_rand(), 1'b1);
		end
		@(negedge clk_sys);
		check_flag("core_ack_o", core_ack, 1'b0);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		core_finish(1'b0, rd);

		// index 3 pulses must not reach memory
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= 8'd3;
		for (int i = 0; i < 8; i++) begin
			idx = pick_loaded();
			ignored.push_back(idx);
			loader_write(idx, 4'hf, next_rand(), 1'b0);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		dl_index  <= '0;
		foreach (ignored[i])
			core_read_check(ignored[i]);
		check_flag("rom_ready_o", rom_ready, 1'b1);

		// reset button holds the system again
		@(posedge clk_sys);
		reset_btn <= 1'b1;
		@(negedge clk_sys);
		check_flag("sys_reset_o", sys_reset, 1'b1);
		check_flag("rom_ready_o", rom_ready, 1'b1);
		@(posedge clk_sys);
		reset_btn <= 1'b0;
		@(negedge clk_sys);
		check_flag("sys_reset_o", sys_reset, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int unsigned RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic arst_n_o
);

	// 10 ns period
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		arst_n_o <= 1'b1;
	end

endmodule
